// File: compile.f
+incdir+verilog
verilog/tracker_pkg.sv
verilog/blob_accumulator.sv
verilog/centroid_divider.sv
verilog/motion_integrator.sv
verilog/led_tracker_top.sv
test/led_tracker_properties.sv
test/tb_led_tracker.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f --top-module tb_led_tracker \
    -Mdir obj_dir -o sim_led_tracker > build.log 2>&1 \
    && { ./obj_dir/sim_led_tracker > sim.log 2>&1; true; } \
    && grep -qx "=== PASS ===" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }

// File: test/led_tracker_properties.sv
`timescale 1ns/10ps

module led_tracker_properties import tracker_pkg::*; (
    input logic   clk_65mhz,
    input logic   rst_n,
    input logic   frame_done,
    input coord_t coord_x [2],
    input coord_t coord_y [2],
    input logic   coord_valid,
    input logic   present [2],
    input logic   motion_valid,
    input logic   punch [2],
    input logic   kick [2]
);

    logic frame_done_q;
    // set once the first frame has been published
    logic first_end_seen;

    always_ff @(posedge clk_65mhz or negedge rst_n) begin
        if (!rst_n) begin
            frame_done_q <= 1'b0;
            first_end_seen <= 1'b0;
        end else begin
            frame_done_q <= frame_done;
            if (frame_done_q && !frame_done) begin
                first_end_seen <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // quiet start
    ////////////////////////////////////////////////////////////////////////////

    idle_after_reset: assert property (@(posedge clk_65mhz) disable iff (!rst_n)
        !first_end_seen |-> !coord_valid && !motion_valid && !present[0] && !present[1] &&
            !punch[0] && !punch[1] && !kick[0] && !kick[1] &&
            (coord_x[0] == '0) && (coord_x[1] == '0) &&
            (coord_y[0] == '0) && (coord_y[1] == '0))
        else $error("outputs not quiet before the first frame ended");

    ////////////////////////////////////////////////////////////////////////////
    // strobes and holds
    ////////////////////////////////////////////////////////////////////////////

    coord_pulse: assert property (@(posedge clk_65mhz) disable iff (!rst_n)
        coord_valid |=> !coord_valid)
        else $error("coord_valid stayed high for more than one cycle");

    motion_pulse: assert property (@(posedge clk_65mhz) disable iff (!rst_n)
        motion_valid |=> !motion_valid)
        else $error("motion_valid stayed high for more than one cycle");

    // player 1 x only moves with its own strobe
    coord_hold: assert property (@(posedge clk_65mhz) disable iff (!rst_n)
        !coord_valid |-> $stable(coord_x[0]))
        else $error("player 1 x coordinate changed without coord_valid");

    punch_1_hold: assert property (@(posedge clk_65mhz) disable iff (!rst_n)
        !motion_valid |-> $stable(punch[0]))
        else $error("player 1 punch changed between motion results");

    punch_2_hold: assert property (@(posedge clk_65mhz) disable iff (!rst_n)
        !motion_valid |-> $stable(punch[1]))
        else $error("player 2 punch changed between motion results");

    kick_1_hold: assert property (@(posedge clk_65mhz) disable iff (!rst_n)
        !motion_valid |-> $stable(kick[0]))
        else $error("player 1 kick changed between motion results");

    kick_2_hold: assert property (@(posedge clk_65mhz) disable iff (!rst_n)
        !motion_valid |-> $stable(kick[1]))
        else $error("player 2 kick changed between motion results");

endmodule

bind led_tracker_top led_tracker_properties u_props (
    .clk_65mhz    (clk_65mhz),
    .rst_n        (rst_n),
    .frame_done   (frame_done),
    .coord_x      (coord_x),
    .coord_y      (coord_y),
    .coord_valid  (coord_valid),
    .present      (present),
    .motion_valid (motion_valid),
    .punch        (punch),
    .kick         (kick)
);

// File: test/tb_led_tracker.sv
`timescale 1ns/10ps

`include "tracker_params.svh"

module tb_led_tracker import tracker_pkg::*; ();

    // 40 frames of about 205 cycles plus margin
    localparam int TIMEOUT_CYCLES = 12000;
    localparam int FRAMES = 40;
    localparam int WIN = 8;
    localparam pixel_t RED_PIX = {4'd14, 4'd2, 4'd1};
    localparam pixel_t WHITE_PIX = {4'd15, 4'd15, 4'd13};
    localparam pixel_t GREY_PIX = {4'd8, 4'd8, 4'd8};

    logic       clk_65mhz;
    logic       rst_n;
    cam_pixel_t pixel;
    logic       frame_done;
    coord_t     coord_x [2];
    coord_t     coord_y [2];
    logic       coord_valid;
    logic       present [2];
    motion_t    motion [2];
    logic       motion_valid;
    logic       punch [2];
    logic       kick [2];

    integer seed = 32'h2ade;
    int     cycle_count = 0;
    int     errors = 0;
    // square top-left corner and edge length per player
    int     sq_x [2];
    int     sq_y [2];
    int     sq_size [2];
    // reference model state
    int     cnt [2];
    int     sum_x [2];
    int     sum_y [2];
    int     cur_x [2];
    int     prev_x [2];
    int     cur_y [2];
    int     prev_y [2];
    int     net_x [2];
    int     net_y [2];
    int     closed_x [2];
    int     closed_y [2];
    int     rise_tally = 0;

    led_tracker_top DUT (
        .clk_65mhz    (clk_65mhz),
        .rst_n        (rst_n),
        .pixel        (pixel),
        .frame_done   (frame_done),
        .coord_x      (coord_x),
        .coord_y      (coord_y),
        .coord_valid  (coord_valid),
        .present      (present),
        .motion       (motion),
        .motion_valid (motion_valid),
        .punch        (punch),
        .kick         (kick)
    );

    initial begin
        clk_65mhz = 1'b0;
        forever #50 clk_65mhz = ~clk_65mhz;
    end

    ////////////////////////////////////////////////////////////////////////////
    // error handling
    ////////////////////////////////////////////////////////////////////////////

    task automatic abort_run();
        errors++;
        $display("=== FAIL ===");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input int got, input int exp);
        $display("[FAIL] time %0t: %s is %0d, expected %0d", $time, name, got, exp);
        abort_run();
    endtask

    task automatic check_value(input string name, input int got, input int exp);
        assert (got == exp) else report_mismatch(name, got, exp);
    endtask

    always @(posedge clk_65mhz) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic drive_pixel(input pixel_t color, input int x, input int y, input logic valid);
        @(posedge clk_65mhz);
        #1;
        pixel.color = color;
        pixel.x = x[`PIX_X_W-1:0];
        pixel.y = y[`PIX_Y_W-1:0];
        pixel.valid = valid;
    endtask

    // near misses that are never red and never white
    function automatic pixel_t noise_color(input int r);
        if (r[2]) begin
            return {4'd15, 4'd15, 4'(r[7:4] % 13)};
        end
        return {4'(r[11:8] % 13), 4'd0, 4'd0};
    endfunction

    // window around one square where the model sums only the square itself
    task automatic stream_window(input int p);
        int     x;
        int     y;
        int     r;
        bit     in_sq;
        pixel_t c;
        for (int row = 0; row < WIN; row++) begin
            for (int col = 0; col < WIN; col++) begin
                x = sq_x[p] - 2 + col;
                y = sq_y[p] - 2 + row;
                in_sq = (x >= sq_x[p]) && (x < sq_x[p] + sq_size[p]) &&
                        (y >= sq_y[p]) && (y < sq_y[p] + sq_size[p]);
                r = $random(seed);
                if (in_sq) begin
                    c = (p == 0) ? RED_PIX : WHITE_PIX;
                    cnt[p]++;
                    sum_x[p] += x;
                    sum_y[p] += y;
                end else if (r[1:0] == 2'b00) begin
                    c = noise_color(r);
                end else begin
                    c = GREY_PIX;
                end
                drive_pixel(c, x, y, 1'b1);
                // red colour on an idle cycle must not count
                if ((col == WIN - 1) && row[0]) begin
                    drive_pixel(RED_PIX, 500, 250, 1'b0);
                end
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // model and checks
    ////////////////////////////////////////////////////////////////////////////

    // add deltas or close the group on frame_done rising
    task automatic model_frame_rise(output bit closing);
        closing = (rise_tally == `FRAME_GROUP - 1);
        for (int p = 0; p < 2; p++) begin
            if (closing) begin
                closed_x[p] = net_x[p];
                closed_y[p] = net_y[p];
                net_x[p] = 0;
                net_y[p] = 0;
            end else begin
                net_x[p] += cur_x[p] - prev_x[p];
                net_y[p] += cur_y[p] - prev_y[p];
            end
        end
        rise_tally = closing ? 0 : rise_tally + 1;
    endtask

    task automatic check_motion();
        int mag_x;
        int mag_y;
        for (int p = 0; p < 2; p++) begin
            mag_x = (closed_x[p] < 0) ? -closed_x[p] : closed_x[p];
            mag_y = (closed_y[p] < 0) ? -closed_y[p] : closed_y[p];
            check_value($sformatf("motion[%0d].dx_mag", p), int'(motion[p].dx_mag), mag_x);
            check_value($sformatf("motion[%0d].dy_mag", p), int'(motion[p].dy_mag), mag_y);
            // zero net has no defined sign
            if (mag_x != 0) begin
                check_value($sformatf("motion[%0d].dx_sign", p), int'(motion[p].dx_sign),
                            int'(closed_x[p] < 0));
            end
            if (mag_y != 0) begin
                check_value($sformatf("motion[%0d].dy_sign", p), int'(motion[p].dy_sign),
                            int'(closed_y[p] < 0));
            end
            check_value($sformatf("punch[%0d]", p), int'(punch[p]), int'(mag_x > `ACTION_MIN));
            check_value($sformatf("kick[%0d]", p), int'(kick[p]), int'(mag_y > `ACTION_MIN));
        end
    endtask

    task automatic update_and_check_centroids();
        for (int p = 0; p < 2; p++) begin
            // empty blob keeps the last centroid
            if (cnt[p] != 0) begin
                prev_x[p] = cur_x[p];
                prev_y[p] = cur_y[p];
                cur_x[p] = sum_x[p] / cnt[p];
                cur_y[p] = sum_y[p] / cnt[p];
            end
            check_value($sformatf("coord_x[%0d].cur", p), int'(coord_x[p].cur), cur_x[p]);
            check_value($sformatf("coord_x[%0d].prev", p), int'(coord_x[p].prev), prev_x[p]);
            check_value($sformatf("coord_y[%0d].cur", p), int'(coord_y[p].cur), cur_y[p]);
            check_value($sformatf("coord_y[%0d].prev", p), int'(coord_y[p].prev), prev_y[p]);
            check_value($sformatf("present[%0d]", p), int'(present[p]),
                        int'(cnt[p] > `MIN_PIXELS));
        end
    endtask

    task automatic run_frame(input int f);
        bit closing;
        for (int p = 0; p < 2; p++) begin
            cnt[p] = 0;
            sum_x[p] = 0;
            sum_y[p] = 0;
        end
        // no red in frame 20 and undersized squares in frames 9 and 27
        sq_size[0] = (f == 20) ? 0 : ((f == 9) ? 2 : 3);
        sq_size[1] = (f == 27) ? 2 : 3;
        stream_window(0);
        stream_window(1);
        drive_pixel(GREY_PIX, 0, 0, 1'b0);
        // blanking stays high for 40 cycles
        @(posedge clk_65mhz);
        #1;
        frame_done = 1'b1;
        model_frame_rise(closing);
        @(posedge clk_65mhz);
        #1;
        check_value("motion_valid", int'(motion_valid), int'(closing));
        if (closing) begin
            check_motion();
        end
        repeat (39) @(posedge clk_65mhz);
        #1;
        frame_done = 1'b0;
        // coord strobe lands exactly 1 + DIV_CYCLES later
        for (int n = 1; n <= 1 + `DIV_CYCLES; n++) begin
            @(posedge clk_65mhz);
            #1;
            if (n < 1 + `DIV_CYCLES) begin
                check_value("coord_valid", int'(coord_valid), 0);
            end else begin
                check_value("coord_valid", int'(coord_valid), int'(cnt[0] != 0));
            end
        end
        update_and_check_centroids();
        // red runs right and then reverses inside the second group
        sq_x[0] += (f < 16) ? 4 : ((f < 24) ? 3 : -3);
        sq_y[0] += (f < 16) ? 1 : 0;
        // white jitters and drifts left in x and drops fast in the second group
        sq_x[1] += (f % 2 == 0) ? 2 : -8;
        sq_y[1] += (f < 16) ? -1 : 4;
    endtask

    initial begin
        rst_n = 1'b0;
        frame_done = 1'b0;
        pixel = '0;
        for (int p = 0; p < 2; p++) begin
            cur_x[p] = 0;
            prev_x[p] = 0;
            cur_y[p] = 0;
            prev_y[p] = 0;
            net_x[p] = 0;
            net_y[p] = 0;
        end
        sq_x[0] = 20;
        sq_y[0] = 30;
        sq_x[1] = 200;
        sq_y[1] = 100;
        repeat (4) @(posedge clk_65mhz);
        #1;
        rst_n = 1'b1;
        for (int f = 0; f < FRAMES; f++) begin
            run_frame(f);
        end
        if (errors == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule

// File: verilog/blob_accumulator.sv
`timescale 1ns/10ps

`include "tracker_params.svh"

module blob_accumulator import tracker_pkg::*; (
    input  logic         clk_65mhz,
    input  logic         rst_n,
    input  cam_pixel_t   pixel,
    input  logic         frame_done,
    output blob_totals_t totals [2],
    output logic         totals_valid,
    output logic         present [2]
);

    // thresholds at channel width
    localparam logic [`CHAN_W-1:0] BRIGHT = `BRIGHT_MIN;
    localparam logic [`CHAN_W-1:0] DARK = `DARK_MAX;
    localparam logic [`COUNT_W-1:0] MIN_CNT = `MIN_PIXELS;

    logic              frame_done_q;
    logic              frame_end;
    logic              is_red;
    logic              is_white;
    logic              hit [2];
    logic [`SUM_W-1:0] x_ext;
    logic [`SUM_W-1:0] y_ext;
    blob_totals_t      acc [2];

    ////////////////////////////////////////////////////////////////////////////
    // pixel classification
    ////////////////////////////////////////////////////////////////////////////

    // end of frame is the falling edge of the blanking level
    assign frame_end = frame_done_q && !frame_done;

    // coordinates widened to the sum width
    assign x_ext = {{(`SUM_W - `PIX_X_W){1'b0}}, pixel.x};
    assign y_ext = {{(`SUM_W - `PIX_Y_W){1'b0}}, pixel.y};

    always_comb begin
        // red led, strong red with green and blue nearly off
        is_red = (pixel.color.red > BRIGHT) &&
                 (pixel.color.green < DARK) &&
                 (pixel.color.blue < DARK);
        // ir led shows up white on the sensor
        is_white = (pixel.color.red > BRIGHT) &&
                   (pixel.color.green > BRIGHT) &&
                   (pixel.color.blue > BRIGHT);
        // the two classes never overlap
        hit[PLAYER_1] = pixel.valid && is_red;
        hit[PLAYER_2] = pixel.valid && is_white;
    end

    ////////////////////////////////////////////////////////////////////////////
    // accumulate, latch and clear
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_65mhz or negedge rst_n) begin
        if (!rst_n) begin
            frame_done_q <= 1'b0;
            totals_valid <= 1'b0;
            for (int p = 0; p < 2; p++) begin
                acc[p] <= '0;
                totals[p] <= '0;
                present[p] <= 1'b0;
            end
        end else begin
            frame_done_q <= frame_done;
            // one-cycle strobe to the dividers
            totals_valid <= frame_end;
            for (int p = 0; p < 2; p++) begin
                // publish the finished frame
                if (frame_end) begin
                    totals[p] <= acc[p];
                    present[p] <= (acc[p].count > MIN_CNT);
                end
                // clear one cycle after publishing
                // a pixel landing here is dropped
                if (totals_valid) begin
                    acc[p] <= '0;
                end else if (hit[p]) begin
                    acc[p].count <= acc[p].count + 1'b1;
                    acc[p].x_sum <= acc[p].x_sum + x_ext;
                    acc[p].y_sum <= acc[p].y_sum + y_ext;
                end
            end
        end
    end

endmodule

// File: verilog/centroid_divider.sv
`timescale 1ns/10ps

`include "tracker_params.svh"

module centroid_divider import tracker_pkg::*; (
    input  logic                clk_65mhz,
    input  logic                rst_n,
    input  logic [`SUM_W-1:0]   sum,
    input  logic [`COUNT_W-1:0] count,
    input  logic                start,
    output coord_t              coord,
    output logic                done
);

    // one load cycle, then one quotient bit per cycle
    localparam int STEP_W = $clog2(`DIV_CYCLES);
    localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(`DIV_CYCLES - 2);

    div_state_e          state;
    logic [STEP_W-1:0]   step;
    // dividend shifts out the top, quotient bits shift in the bottom
    logic [`SUM_W-1:0]   dvd;
    logic [`SUM_W-1:0]   dvd_next;
    logic [`COUNT_W-1:0] dsr;
    logic [`COUNT_W-1:0] rem;
    logic [`COUNT_W-1:0] rem_next;
    logic [`COUNT_W:0]   rem_shift;
    logic [`COUNT_W:0]   rem_diff;
    logic                q_bit;

    ////////////////////////////////////////////////////////////////////////////
    // restoring step
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        // bring down the next dividend bit
        rem_shift = {rem, dvd[`SUM_W-1]};
        rem_diff = rem_shift - {1'b0, dsr};
        // subtract only if it fits
        q_bit = (rem_shift >= {1'b0, dsr});
        rem_next = q_bit ? rem_diff[`COUNT_W-1:0] : rem_shift[`COUNT_W-1:0];
        dvd_next = {dvd[`SUM_W-2:0], q_bit};
    end

    // result strobe lasts the single DIV_DONE cycle
    assign done = (state == DIV_DONE);

    ////////////////////////////////////////////////////////////////////////////
    // control FSM and coordinate registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_65mhz or negedge rst_n) begin
        if (!rst_n) begin
            state <= DIV_IDLE;
            step <= '0;
            coord <= '0;
        end else begin
            case (state)
                DIV_IDLE: begin
                    // empty blob keeps the old centroid
                    if (start && (count != '0)) begin
                        state <= DIV_RUN;
                        step <= '0;
                    end
                end
                DIV_RUN: begin
                    step <= step + 1'b1;
                    // last bit goes straight into the coordinate
                    if (step == LAST_STEP) begin
                        state <= DIV_DONE;
                        coord.prev <= coord.cur;
                        coord.cur <= dvd_next[`PIX_X_W-1:0];
                    end
                end
                DIV_DONE: begin
                    state <= DIV_IDLE;
                end
                default: begin
                    state <= DIV_IDLE;
                end
            endcase
        end
    end

    // datapath
    always_ff @(posedge clk_65mhz) begin
        if ((state == DIV_IDLE) && start) begin
            dvd <= sum;
            dsr <= count;
            rem <= '0;
        end else if (state == DIV_RUN) begin
            dvd <= dvd_next;
            rem <= rem_next;
        end
    end

endmodule

// File: verilog/led_tracker_top.sv
`timescale 1ns/10ps

module led_tracker_top import tracker_pkg::*; (
    input  logic       clk_65mhz,
    input  logic       rst_n,
    input  cam_pixel_t pixel,
    input  logic       frame_done,
    output coord_t     coord_x [2],
    output coord_t     coord_y [2],
    output logic       coord_valid,
    output logic       present [2],
    output motion_t    motion [2],
    output logic       motion_valid,
    output logic       punch [2],
    output logic       kick [2]
);

    blob_totals_t totals [2];
    logic         totals_valid;

    ////////////////////////////////////////////////////////////////////////////
    // stage 1, per-frame blob totals
    ////////////////////////////////////////////////////////////////////////////

    blob_accumulator u_blob (
        .clk_65mhz    (clk_65mhz),
        .rst_n        (rst_n),
        .pixel        (pixel),
        .frame_done   (frame_done),
        .totals       (totals),
        .totals_valid (totals_valid),
        .present      (present)
    );

    ////////////////////////////////////////////////////////////////////////////
    // stage 2, centroid division
    ////////////////////////////////////////////////////////////////////////////

    // player 1 x sets the coordinate strobe
    centroid_divider u_div_p1_x (
        .clk_65mhz (clk_65mhz),
        .rst_n     (rst_n),
        .sum       (totals[PLAYER_1].x_sum),
        .count     (totals[PLAYER_1].count),
        .start     (totals_valid),
        .coord     (coord_x[PLAYER_1]),
        .done      (coord_valid)
    );

    // the other three finish in the same cycle when their blob is seen
    centroid_divider u_div_p1_y (
        .clk_65mhz (clk_65mhz),
        .rst_n     (rst_n),
        .sum       (totals[PLAYER_1].y_sum),
        .count     (totals[PLAYER_1].count),
        .start     (totals_valid),
        .coord     (coord_y[PLAYER_1]),
        .done      ()
    );

    centroid_divider u_div_p2_x (
        .clk_65mhz (clk_65mhz),
        .rst_n     (rst_n),
        .sum       (totals[PLAYER_2].x_sum),
        .count     (totals[PLAYER_2].count),
        .start     (totals_valid),
        .coord     (coord_x[PLAYER_2]),
        .done      ()
    );

    centroid_divider u_div_p2_y (
        .clk_65mhz (clk_65mhz),
        .rst_n     (rst_n),
        .sum       (totals[PLAYER_2].y_sum),
        .count     (totals[PLAYER_2].count),
        .start     (totals_valid),
        .coord     (coord_y[PLAYER_2]),
        .done      ()
    );

    ////////////////////////////////////////////////////////////////////////////
    // stage 3, motion over frame groups
    ////////////////////////////////////////////////////////////////////////////

    motion_integrator u_motion (
        .clk_65mhz    (clk_65mhz),
        .rst_n        (rst_n),
        .frame_done   (frame_done),
        .coord_x      (coord_x),
        .coord_y      (coord_y),
        .motion       (motion),
        .motion_valid (motion_valid),
        .punch        (punch),
        .kick         (kick)
    );

endmodule

// File: verilog/motion_integrator.sv
`timescale 1ns/10ps

`include "tracker_params.svh"

module motion_integrator import tracker_pkg::*; (
    input  logic    clk_65mhz,
    input  logic    rst_n,
    input  logic    frame_done,
    input  coord_t  coord_x [2],
    input  coord_t  coord_y [2],
    output motion_t motion [2],
    output logic    motion_valid,
    output logic    punch [2],
    output logic    kick [2]
);

    localparam int TALLY_W = $clog2(`FRAME_GROUP);
    localparam logic [TALLY_W-1:0] LAST_FRAME = TALLY_W'(`FRAME_GROUP - 1);
    localparam logic [`MOTION_W-1:0] ACTION_LIM = `ACTION_MIN;

    logic                 frame_done_q;
    logic                 frame_start;
    logic [TALLY_W-1:0]   frame_tally;
    motion_t              acc [2];
    // {sign, magnitude} after adding this frame's delta
    logic [`MOTION_W:0]   next_x [2];
    logic [`MOTION_W:0]   next_y [2];

    // two-frame delta as {sign, magnitude}
    function automatic logic [`MOTION_W:0] two_frame_delta(input coord_t c);
        logic [`MOTION_W-1:0] cur_ext;
        logic [`MOTION_W-1:0] prev_ext;
        cur_ext = {{(`MOTION_W - `PIX_X_W){1'b0}}, c.cur};
        prev_ext = {{(`MOTION_W - `PIX_X_W){1'b0}}, c.prev};
        // moved towards zero
        if (c.prev > c.cur) begin
            return {1'b1, prev_ext - cur_ext};
        end
        return {1'b0, cur_ext - prev_ext};
    endfunction

    // sign-magnitude add of a delta into a running sum
    function automatic logic [`MOTION_W:0] sm_add(
        input logic [`MOTION_W-1:0] a_mag,
        input logic                 a_sign,
        input logic [`MOTION_W:0]   d
    );
        logic                 d_sign;
        logic [`MOTION_W-1:0] d_mag;
        d_sign = d[`MOTION_W];
        d_mag = d[`MOTION_W-1:0];
        if (a_sign == d_sign) begin
            return {a_sign, a_mag + d_mag};
        end
        // opposite signs, larger one wins
        if (a_mag > d_mag) begin
            return {a_sign, a_mag - d_mag};
        end
        // ties take the delta's sign
        return {d_sign, d_mag - a_mag};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // frame edge and next sums
    ////////////////////////////////////////////////////////////////////////////

    assign frame_start = frame_done && !frame_done_q;

    always_comb begin
        for (int p = 0; p < 2; p++) begin
            next_x[p] = sm_add(acc[p].dx_mag, acc[p].dx_sign, two_frame_delta(coord_x[p]));
            next_y[p] = sm_add(acc[p].dy_mag, acc[p].dy_sign, two_frame_delta(coord_y[p]));
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // group integration and action decode
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_65mhz or negedge rst_n) begin
        if (!rst_n) begin
            frame_done_q <= 1'b0;
            frame_tally <= '0;
            motion_valid <= 1'b0;
            for (int p = 0; p < 2; p++) begin
                acc[p] <= '0;
                motion[p] <= '0;
                punch[p] <= 1'b0;
                kick[p] <= 1'b0;
            end
        end else begin
            frame_done_q <= frame_done;
            motion_valid <= 1'b0;
            if (frame_start) begin
                if (frame_tally == LAST_FRAME) begin
                    // close the group
                    frame_tally <= '0;
                    motion_valid <= 1'b1;
                    for (int p = 0; p < 2; p++) begin
                        motion[p] <= acc[p];
                        // actions hold until the next group closes
                        punch[p] <= (acc[p].dx_mag > ACTION_LIM);
                        kick[p] <= (acc[p].dy_mag > ACTION_LIM);
                        acc[p] <= '0;
                    end
                end else begin
                    frame_tally <= frame_tally + 1'b1;
                    for (int p = 0; p < 2; p++) begin
                        acc[p].dx_sign <= next_x[p][`MOTION_W];
                        acc[p].dx_mag <= next_x[p][`MOTION_W-1:0];
                        acc[p].dy_sign <= next_y[p][`MOTION_W];
                        acc[p].dy_mag <= next_y[p][`MOTION_W-1:0];
                    end
                end
            end
        end
    end

endmodule

// File: verilog/tracker_params.svh
`ifndef TRACKER_PARAMS_SVH
`define TRACKER_PARAMS_SVH

// pixel coordinate widths
`define PIX_X_W 9
`define PIX_Y_W 8

// one colour channel of a camera pixel
`define CHAN_W 4

// per-frame pixel count and coordinate sum widths
`define COUNT_W 16
`define SUM_W 24

// sixteen-frame motion magnitude
`define MOTION_W 13

// colour classification thresholds
`define BRIGHT_MIN 12
`define DARK_MAX 3

// blob must be bigger than this to count as present
`define MIN_PIXELS 5

// net movement above this is a punch or a kick
`define ACTION_MIN 32

// frames per motion group
`define FRAME_GROUP 16

// divider latency, one load cycle plus one cycle per dividend bit
`define DIV_CYCLES 25

`endif

// File: verilog/tracker_pkg.sv
package tracker_pkg;

`include "tracker_params.svh"

    // 4:4:4 colour pixel
    typedef struct packed {
        logic [`CHAN_W-1:0] red;
        logic [`CHAN_W-1:0] green;
        logic [`CHAN_W-1:0] blue;
    } pixel_t;

    // one streamed camera pixel
    // x is already mirrored to screen orientation
    typedef struct packed {
        pixel_t              color;
        logic [`PIX_X_W-1:0] x;
        logic [`PIX_Y_W-1:0] y;
        logic                valid;
    } cam_pixel_t;

    // per-player frame totals
    typedef struct packed {
        logic [`COUNT_W-1:0] count;
        logic [`SUM_W-1:0]   x_sum;
        logic [`SUM_W-1:0]   y_sum;
    } blob_totals_t;

    // one centroid axis
    // y fits in the x width, so both axes share this type
    typedef struct packed {
        logic [`PIX_X_W-1:0] cur;
        logic [`PIX_X_W-1:0] prev;
    } coord_t;

    // net movement over one frame group
    // sign bits are 1 for negative
    typedef struct packed {
        logic [`MOTION_W-1:0] dx_mag;
        logic                 dx_sign;
        logic [`MOTION_W-1:0] dy_mag;
        logic                 dy_sign;
    } motion_t;

    // player index for the per-player arrays
    typedef enum logic {
        PLAYER_1 = 1'b0,
        PLAYER_2 = 1'b1
    } player_e;

    // divider FSM
    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_e;

endpackage
